/* source/rv32i_pkg.sv */
package rv32i_pkg;

    // ************************************************************************
    // Basic types
    // ************************************************************************

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // ************************************************************************
    // Function codes, one view per instruction class
    // ************************************************************************

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // Same three bits, meaning depends on the opcode
    typedef union packed {
        arith_funct3_t  arith;
        branch_funct3_t branch;
        load_funct3_t   load;
        store_funct3_t  store;
    } funct3_u;

    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        funct3_u    funct3;
        logic       funct7_5;
        logic [4:0] rd;
        logic       use_imm;
    } ctrl_word_t;

    typedef enum logic [1:0] {
        pc_plus4        = 2'b00,
        alu_target      = 2'b01,
        alu_target_even = 2'b10
    } pc_sel_t;

endpackage

/* source/ex_mem_if.sv */
interface ex_mem_if;

    rv32i_pkg::ctrl_word_t ctrl;
    rv32i_pkg::word_t      alu;
    rv32i_pkg::word_t      link;
    rv32i_pkg::word_t      rs2;
    logic [3:0]            byte_en;
    logic                  read;
    logic                  write;
    rv32i_pkg::pc_sel_t    pc_sel;

    // Driven by the EX/MEM register and its decode
    modport stage (
        output ctrl, alu, link, rs2, byte_en, read, write, pc_sel
    );

    // Seen by the memory access block
    modport mem (
        input ctrl, alu, link, rs2, byte_en, read, write, pc_sel
    );

endinterface

/* source/exec_unit.sv */
module exec_unit (
    input  rv32i_pkg::ctrl_word_t ctrl,
    input  rv32i_pkg::word_t      pc,
    input  rv32i_pkg::word_t      rs1_val,
    input  rv32i_pkg::word_t      rs2_val,
    input  rv32i_pkg::word_t      imm,
    output rv32i_pkg::word_t      alu_result,
    output rv32i_pkg::word_t      link,
    output logic                  br_en
);

    rv32i_pkg::word_t op_a;
    rv32i_pkg::word_t op_b;
    logic             reg_reg;
    logic [4:0]       shamt;

    assign reg_reg = (ctrl.opcode == rv32i_pkg::op_reg) && !ctrl.use_imm;

    // PC-relative forms take the PC as first operand
    assign op_a = (ctrl.opcode == rv32i_pkg::op_auipc ||
                   ctrl.opcode == rv32i_pkg::op_jal ||
                   ctrl.opcode == rv32i_pkg::op_br) ? pc : rs1_val;
    assign op_b  = reg_reg ? rs2_val : imm;
    assign shamt = op_b[4:0];

    assign link = pc + 32'd4;

    always_comb begin
        case (ctrl.opcode)
            rv32i_pkg::op_lui: alu_result = imm;
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                case (ctrl.funct3.arith)
                    rv32i_pkg::add:  alu_result = (reg_reg && ctrl.funct7_5) ?
                                                  op_a - op_b : op_a + op_b;
                    rv32i_pkg::sll:  alu_result = op_a << shamt;
                    rv32i_pkg::slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
                    rv32i_pkg::sltu: alu_result = {31'b0, op_a < op_b};
                    rv32i_pkg::axor: alu_result = op_a ^ op_b;
                    rv32i_pkg::sr: begin
                        if (ctrl.funct7_5)
                            alu_result = $unsigned($signed(op_a) >>> shamt);
                        else
                            alu_result = op_a >> shamt;
                    end
                    rv32i_pkg::aor:  alu_result = op_a | op_b;
                    default:         alu_result = op_a & op_b;
                endcase
            end
            // auipc, jumps, branches and memory ops all add
            default: alu_result = op_a + op_b;
        endcase
    end

    // Branch condition on the register operands
    always_comb begin
        br_en = 1'b0;
        if (ctrl.opcode == rv32i_pkg::op_br) begin
            case (ctrl.funct3.branch)
                rv32i_pkg::beq:  br_en = rs1_val == rs2_val;
                rv32i_pkg::bne:  br_en = rs1_val != rs2_val;
                rv32i_pkg::blt:  br_en = $signed(rs1_val) < $signed(rs2_val);
                rv32i_pkg::bge:  br_en = $signed(rs1_val) >= $signed(rs2_val);
                rv32i_pkg::bltu: br_en = rs1_val < rs2_val;
                rv32i_pkg::bgeu: br_en = rs1_val >= rs2_val;
                default:         br_en = 1'b0;
            endcase
        end
    end

endmodule

/* source/ex_mem_stage.sv */
module ex_mem_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32i_pkg::ctrl_word_t ctrl_in,
    input  rv32i_pkg::word_t      alu_in,
    input  rv32i_pkg::word_t      link_in,
    input  rv32i_pkg::word_t      rs2_in,
    input  logic                  br_en_in,
    ex_mem_if.stage               mem
);

    rv32i_pkg::ctrl_word_t ctrl_q;
    rv32i_pkg::word_t      alu_q;
    rv32i_pkg::word_t      link_q;
    rv32i_pkg::word_t      rs2_q;
    logic                  br_en_q;
    logic                  is_load;
    logic                  is_store;
    logic                  is_byte;
    logic                  is_half;

    // ************************************************************************
    // Stage register
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q  <= '0;
            alu_q   <= '0;
            link_q  <= '0;
            rs2_q   <= '0;
            br_en_q <= 1'b0;
        end else begin
            ctrl_q  <= ctrl_in;
            alu_q   <= alu_in;
            link_q  <= link_in;
            rs2_q   <= rs2_in;
            br_en_q <= br_en_in;
        end
    end

    assign mem.ctrl = ctrl_q;
    assign mem.alu  = alu_q;
    assign mem.link = link_q;
    assign mem.rs2  = rs2_q;

    // ************************************************************************
    // Memory and next-PC decode
    // ************************************************************************

    assign is_load  = ctrl_q.opcode == rv32i_pkg::op_load;
    assign is_store = ctrl_q.opcode == rv32i_pkg::op_store;

    assign mem.read  = ctrl_q.valid && is_load;
    assign mem.write = ctrl_q.valid && is_store;

    // Access size from the load or store view
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        if (is_load) begin
            case (ctrl_q.funct3.load)
                rv32i_pkg::lb, rv32i_pkg::lbu: is_byte = 1'b1;
                rv32i_pkg::lh, rv32i_pkg::lhu: is_half = 1'b1;
                default: ;
            endcase
        end else if (is_store) begin
            case (ctrl_q.funct3.store)
                rv32i_pkg::sb: is_byte = 1'b1;
                rv32i_pkg::sh: is_half = 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        mem.byte_en = 4'b1111;
        if (is_byte) begin
            mem.byte_en = 4'b0001 << alu_q[1:0];
        end else if (is_half) begin
            case (alu_q[1:0])
                2'b01:   mem.byte_en = 4'b0110;
                2'b10:   mem.byte_en = 4'b1100;
                default: mem.byte_en = 4'b0011;  // offset 3 wraps to lanes 0 and 1
            endcase
        end
    end

    always_comb begin
        mem.pc_sel = rv32i_pkg::pc_plus4;
        if (ctrl_q.valid) begin
            case (ctrl_q.opcode)
                rv32i_pkg::op_br:   if (br_en_q) mem.pc_sel = rv32i_pkg::alu_target;
                rv32i_pkg::op_jal:  mem.pc_sel = rv32i_pkg::alu_target;
                rv32i_pkg::op_jalr: mem.pc_sel = rv32i_pkg::alu_target_even;
                default: ;
            endcase
        end
    end

endmodule

/* source/mem_access.sv */
module mem_access (
    ex_mem_if.mem            mem,
    input  rv32i_pkg::word_t ram_rdata,
    output logic [29:0]      ram_addr,
    output logic [3:0]       ram_be,
    output rv32i_pkg::word_t ram_wdata,
    output logic             out_valid,
    output logic             out_we,
    output logic [4:0]       out_rd,
    output rv32i_pkg::word_t out_data,
    output logic             redirect,
    output rv32i_pkg::word_t redirect_pc
);

    logic [7:0]       lane_byte;
    logic [15:0]      lane_half;
    rv32i_pkg::word_t load_val;
    logic             is_jump;

    assign ram_addr = mem.alu[31:2];
    assign ram_be   = mem.write ? mem.byte_en : 4'b0000;

    // Store data copied onto every lane, byte enables pick the target
    always_comb begin
        case (mem.ctrl.funct3.store)
            rv32i_pkg::sb: ram_wdata = {4{mem.rs2[7:0]}};
            rv32i_pkg::sh: begin
                // Offset 1 straddles lanes 1 and 2
                if (mem.alu[1:0] == 2'b01)
                    ram_wdata = {8'b0, mem.rs2[15:0], 8'b0};
                else
                    ram_wdata = {2{mem.rs2[15:0]}};
            end
            default:       ram_wdata = mem.rs2;
        endcase
    end

    // Lane selection for sub-word loads
    always_comb begin
        case (mem.alu[1:0])
            2'b00: begin
                lane_byte = ram_rdata[7:0];
                lane_half = ram_rdata[15:0];
            end
            2'b01: begin
                lane_byte = ram_rdata[15:8];
                lane_half = ram_rdata[23:8];
            end
            2'b10: begin
                lane_byte = ram_rdata[23:16];
                lane_half = ram_rdata[31:16];
            end
            default: begin
                lane_byte = ram_rdata[31:24];
                lane_half = ram_rdata[15:0];
            end
        endcase
        case (mem.ctrl.funct3.load)
            rv32i_pkg::lb:  load_val = {{24{lane_byte[7]}}, lane_byte};
            rv32i_pkg::lbu: load_val = {24'b0, lane_byte};
            rv32i_pkg::lh:  load_val = {{16{lane_half[15]}}, lane_half};
            rv32i_pkg::lhu: load_val = {16'b0, lane_half};
            default:        load_val = ram_rdata;
        endcase
    end

    assign is_jump = mem.ctrl.opcode == rv32i_pkg::op_jal ||
                     mem.ctrl.opcode == rv32i_pkg::op_jalr;

    assign out_data = mem.read ? load_val : (is_jump ? mem.link : mem.alu);

    assign out_valid = mem.ctrl.valid;
    assign out_rd    = mem.ctrl.rd;
    assign out_we    = mem.ctrl.valid && (mem.ctrl.rd != 5'd0) &&
                       mem.ctrl.opcode != rv32i_pkg::op_store &&
                       mem.ctrl.opcode != rv32i_pkg::op_br;

    assign redirect    = mem.pc_sel != rv32i_pkg::pc_plus4;
    assign redirect_pc = (mem.pc_sel == rv32i_pkg::alu_target_even) ?
                         {mem.alu[31:1], 1'b0} : mem.alu;

endmodule

/* source/data_ram.sv */
module data_ram #(
    parameter int DATA_WORDS = 256
) (
    input  logic             clk,
    input  logic [29:0]      addr,
    input  logic [3:0]       be,
    input  rv32i_pkg::word_t wdata,
    output rv32i_pkg::word_t rdata
);

    localparam int ADDR_W = $clog2(DATA_WORDS);

    rv32i_pkg::word_t mem_array [DATA_WORDS];
    logic [ADDR_W-1:0] index;

    // Upper word-address bits alias onto the array
    assign index = addr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                mem_array[index][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    assign rdata = mem_array[index];

endmodule

/* source/ex_mem_top.sv */
module ex_mem_top #(
    parameter int DATA_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7_5,
    input  logic [4:0]  rd,
    input  logic        use_imm,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [31:0] imm,
    output logic        out_valid,
    output logic        out_we,
    output logic [4:0]  out_rd,
    output logic [31:0] out_data,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    rv32i_pkg::ctrl_word_t ctrl_in;
    rv32i_pkg::word_t      alu_result;
    rv32i_pkg::word_t      link;
    logic                  br_en;
    logic [29:0]           ram_addr;
    logic [3:0]            ram_be;
    rv32i_pkg::word_t      ram_wdata;
    rv32i_pkg::word_t      ram_rdata;

    ex_mem_if ex_mem_bus ();

    // Field order follows ctrl_word_t
    assign ctrl_in = {in_valid, opcode, funct3, funct7_5, rd, use_imm};

    exec_unit exec_i (
        .ctrl       (ctrl_in),
        .pc         (pc),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .imm        (imm),
        .alu_result (alu_result),
        .link       (link),
        .br_en      (br_en)
    );

    ex_mem_stage stage_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl_in  (ctrl_in),
        .alu_in   (alu_result),
        .link_in  (link),
        .rs2_in   (rs2_val),
        .br_en_in (br_en),
        .mem      (ex_mem_bus.stage)
    );

    mem_access access_i (
        .mem         (ex_mem_bus.mem),
        .ram_rdata   (ram_rdata),
        .ram_addr    (ram_addr),
        .ram_be      (ram_be),
        .ram_wdata   (ram_wdata),
        .out_valid   (out_valid),
        .out_we      (out_we),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    data_ram #(
        .DATA_WORDS (DATA_WORDS)
    ) ram_i (
        .clk   (clk),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* tb/ex_mem_chk.sv */
module ex_mem_chk (
    input logic                  clk,
    input logic                  rst,
    input rv32i_pkg::ctrl_word_t ctrl_q,
    input logic                  read,
    input logic                  write,
    input logic [3:0]            byte_en,
    input rv32i_pkg::pc_sel_t    pc_sel
);

    int   fail_count = 0;
    logic is_flow;

    assign is_flow = ctrl_q.opcode == rv32i_pkg::op_br ||
                     ctrl_q.opcode == rv32i_pkg::op_jal ||
                     ctrl_q.opcode == rv32i_pkg::op_jalr;

    no_read_write: assert property (@(posedge clk) disable iff (rst) !(read && write))
    else begin
        fail_count++;
        $error("read and write strobes high together");
    end

    invalid_after_reset: assert property (@(posedge clk) rst |=> !ctrl_q.valid)
    else begin
        fail_count++;
        $error("stage register holds a valid control word after reset");
    end

    lanes_on_access: assert property (@(posedge clk) disable iff (rst)
        (read || write) |-> byte_en != 4'b0000)
    else begin
        fail_count++;
        $error("memory access with no byte lane enabled");
    end

    // Only branches and jumps may leave the sequential path
    plus4_for_others: assert property (@(posedge clk) disable iff (rst)
        !is_flow |-> pc_sel == rv32i_pkg::pc_plus4)
    else begin
        fail_count++;
        $error("next-PC select moved for an instruction that is not a branch or jump");
    end

endmodule

bind ex_mem_stage ex_mem_chk chk_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl_q  (ctrl_q),
    .read    (mem.read),
    .write   (mem.write),
    .byte_en (mem.byte_en),
    .pc_sel  (mem.pc_sel)
);

/* tb/ex_mem_tb.sv */
module ex_mem_tb;

    localparam int DATA_WORDS   = 256;
    localparam int IDX_W        = $clog2(DATA_WORDS);
    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_ALU        = 300;
    localparam int N_BRANCH     = 20;
    localparam int N_JUMP       = 20;
    localparam int MEM_ROUNDS   = 2;
    localparam int N_MIX        = 400;
    localparam int TOTAL_INSTR  = 6 + DATA_WORDS + N_ALU + 6 * N_BRANCH + 2 * N_JUMP +
                                  MEM_ROUNDS * 12 * 21 + N_MIX;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        check_data;
        logic        redirect;
        logic [31:0] target;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_5;
    logic [4:0]  rd;
    logic        use_imm;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic        out_valid;
    logic        out_we;
    logic [4:0]  out_rd;
    logic [31:0] out_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    integer      seed = 96;
    int          mismatches = 0;
    int          cycles_checked = 0;
    logic [31:0] model_mem [DATA_WORDS];
    expect_t     ex_rec = '0;
    expect_t     mem_rec = '0;

    tb_clock #(.PERIOD(PERIOD)) clock_i (.clk(clk));

    ex_mem_top #(
        .DATA_WORDS (DATA_WORDS)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7_5    (funct7_5),
        .rd          (rd),
        .use_imm     (use_imm),
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .imm         (imm),
        .out_valid   (out_valid),
        .out_we      (out_we),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // ************************************************************************
    // Random helpers
    // ************************************************************************

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [31:0] r;
        r = $random(seed);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    // Roughly one in eight destinations is x0
    function automatic logic [4:0] rand_rd();
        logic [31:0] r;
        r = $random(seed);
        return (r[2:0] == 3'd0) ? 5'd0 : r[7:3];
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h9e37_79b9 * (i + 1);
    endfunction

    function automatic logic [2:0] load_funct3(input int k);
        case (k)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    // ************************************************************************
    // Reference model
    // ************************************************************************

    function automatic expect_t reference_result(
        input logic [6:0]  op,
        input logic [2:0]  f3,
        input logic        f7,
        input logic [4:0]  rd_v,
        input logic [31:0] pc_v,
        input logic [31:0] a,
        input logic [31:0] b_reg,
        input logic [31:0] imm_v
    );
        expect_t     e;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] word;
        logic [1:0]  off;
        logic [7:0]  bsel;
        logic [15:0] hsel;
        int          idx;
        e = '0;
        e.valid = 1'b1;
        e.rd = rd_v;
        e.we = rd_v != 5'd0 && op != rv32i_pkg::op_store && op != rv32i_pkg::op_br;
        e.check_data = 1'b1;
        addr = a + imm_v;
        off = addr[1:0];
        idx = addr[IDX_W+1:2];
        case (op)
            rv32i_pkg::op_lui:   e.data = imm_v;
            rv32i_pkg::op_auipc: e.data = pc_v + imm_v;
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                b = (op == rv32i_pkg::op_reg) ? b_reg : imm_v;
                case (f3)
                    3'b000: e.data = (op == rv32i_pkg::op_reg && f7) ? a - b : a + b;
                    3'b001: e.data = a << b[4:0];
                    3'b010: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: e.data = (a < b) ? 32'd1 : 32'd0;
                    3'b100: e.data = a ^ b;
                    3'b101: begin
                        // Arithmetic form fills the vacated top bits with the sign
                        e.data = a >> b[4:0];
                        if (f7 && a[31])
                            e.data = e.data | ~(32'hffff_ffff >> b[4:0]);
                    end
                    3'b110: e.data = a | b;
                    default: e.data = a & b;
                endcase
            end
            rv32i_pkg::op_jal: begin
                e.data = pc_v + 32'd4;
                e.redirect = 1'b1;
                e.target = pc_v + imm_v;
            end
            rv32i_pkg::op_jalr: begin
                e.data = pc_v + 32'd4;
                e.redirect = 1'b1;
                e.target = {addr[31:1], 1'b0};
            end
            rv32i_pkg::op_br: begin
                e.check_data = 1'b0;
                case (f3)
                    3'b000:  e.redirect = a == b_reg;
                    3'b001:  e.redirect = a != b_reg;
                    3'b100:  e.redirect = $signed(a) < $signed(b_reg);
                    3'b101:  e.redirect = $signed(a) >= $signed(b_reg);
                    3'b110:  e.redirect = a < b_reg;
                    3'b111:  e.redirect = a >= b_reg;
                    default: e.redirect = 1'b0;
                endcase
                e.target = pc_v + imm_v;
            end
            rv32i_pkg::op_store: begin
                e.check_data = 1'b0;
                word = model_mem[idx];
                if (f3 == 3'b000) begin
                    word[off*8 +: 8] = b_reg[7:0];
                end else if (f3 == 3'b001) begin
                    case (off)
                        2'd1:    word[23:8] = b_reg[15:0];
                        2'd2:    word[31:16] = b_reg[15:0];
                        default: word[15:0] = b_reg[15:0];
                    endcase
                end else begin
                    word = b_reg;
                end
                model_mem[idx] = word;
            end
            default: begin
                // Loads
                word = model_mem[idx];
                bsel = word[off*8 +: 8];
                case (off)
                    2'd1:    hsel = word[23:8];
                    2'd2:    hsel = word[31:16];
                    default: hsel = word[15:0];
                endcase
                case (f3)
                    3'b000:  e.data = {{24{bsel[7]}}, bsel};
                    3'b001:  e.data = {{16{hsel[15]}}, hsel};
                    3'b100:  e.data = {24'b0, bsel};
                    3'b101:  e.data = {16'b0, hsel};
                    default: e.data = word;
                endcase
            end
        endcase
        return e;
    endfunction

    // ************************************************************************
    // Stimulus tasks
    // ************************************************************************

    task automatic send(
        input logic [6:0]  op_v,
        input logic [2:0]  f3_v,
        input logic        f7_v,
        input logic [4:0]  rd_v,
        input logic [31:0] pc_v,
        input logic [31:0] rs1_v,
        input logic [31:0] rs2_v,
        input logic [31:0] imm_v
    );
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        opcode   = op_v;
        funct3   = f3_v;
        funct7_5 = f7_v;
        rd       = rd_v;
        use_imm  = op_v != rv32i_pkg::op_reg;
        pc       = pc_v;
        rs1_val  = rs1_v;
        rs2_val  = rs2_v;
        imm      = imm_v;
        ex_rec   = reference_result(op_v, f3_v, f7_v, rd_v, pc_v, rs1_v, rs2_v, imm_v);
    endtask

    task automatic send_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        ex_rec = '0;
    endtask

    task automatic send_alu(input int kind);
        logic [6:0]  op_v;
        logic [2:0]  f3_v;
        logic        f7_v;
        logic [31:0] imm_v;
        logic [31:0] r;
        r = rand_word();
        op_v = r[0] ? rv32i_pkg::op_imm : rv32i_pkg::op_reg;
        f7_v = 1'b0;
        imm_v = rand_imm12();
        f3_v = 3'b111;
        case (kind)
            0: f3_v = 3'b000;
            1: begin
                op_v = rv32i_pkg::op_reg;
                f3_v = 3'b000;
                f7_v = 1'b1;
            end
            2: f3_v = 3'b001;
            3: f3_v = 3'b010;
            4: f3_v = 3'b011;
            5: f3_v = 3'b100;
            6: f3_v = 3'b101;
            7: begin
                f3_v = 3'b101;
                f7_v = 1'b1;
            end
            8: f3_v = 3'b110;
            10: op_v = rv32i_pkg::op_lui;
            11: op_v = rv32i_pkg::op_auipc;
            default: f3_v = 3'b111;
        endcase
        if (kind == 2 || kind == 6 || kind == 7) begin
            imm_v = {27'b0, r[5:1]};
        end
        if (kind >= 10) begin
            imm_v = {r[31:12], 12'b0};
        end
        send(op_v, f3_v, f7_v, rand_rd(), rand_pc(), rand_word(), rand_word(), imm_v);
    endtask

    task automatic send_branch(input int k);
        logic [2:0]  f3_v;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        case (k)
            0:       f3_v = 3'b000;
            1:       f3_v = 3'b001;
            2:       f3_v = 3'b100;
            3:       f3_v = 3'b101;
            4:       f3_v = 3'b110;
            default: f3_v = 3'b111;
        endcase
        a = rand_word();
        r = rand_word();
        // Equal and sign-flipped operands reach both sides of each compare
        case (r[1:0])
            2'd0:    b = a;
            2'd1:    b = a ^ 32'h8000_0000;
            default: b = rand_word();
        endcase
        send(rv32i_pkg::op_br, f3_v, 1'b0, rand_rd(), rand_pc(), a, b,
             {{19{r[14]}}, r[14:3], 1'b0});
    endtask

    task automatic send_jump(input logic is_jalr);
        logic [31:0] r;
        r = rand_word();
        if (is_jalr) begin
            send(rv32i_pkg::op_jalr, 3'b000, 1'b0, rand_rd(), rand_pc(), rand_word(),
                 rand_word(), rand_imm12());
        end else begin
            send(rv32i_pkg::op_jal, 3'b000, 1'b0, rand_rd(), rand_pc(), rand_word(),
                 rand_word(), {{11{r[20]}}, r[20:1], 1'b0});
        end
    endtask

    task automatic send_mem(input logic [6:0] op_v, input logic [2:0] f3_v,
                            input logic [31:0] addr);
        logic [31:0] imm_v;
        imm_v = rand_imm12();
        send(op_v, f3_v, 1'b0, rand_rd(), rand_pc(), addr - imm_v, rand_word(), imm_v);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        mismatches++;
        $display("[FAIL] %s got %h expected %h at time %0t", name, got, want, $time);
    endtask

    // ************************************************************************
    // Comparison, one cycle behind the driven instruction
    // ************************************************************************

    always @(posedge clk) begin
        mem_rec <= ex_rec;
    end

    always @(negedge clk) begin
        cycles_checked++;
        if (out_valid !== mem_rec.valid) begin
            report_mismatch("out_valid", out_valid, mem_rec.valid);
        end
        if (out_we !== mem_rec.we) begin
            report_mismatch("out_we", out_we, mem_rec.we);
        end
        if (redirect !== mem_rec.redirect) begin
            report_mismatch("redirect", redirect, mem_rec.redirect);
        end
        if (mem_rec.valid && out_rd !== mem_rec.rd) begin
            report_mismatch("out_rd", out_rd, mem_rec.rd);
        end
        if (mem_rec.check_data && out_data !== mem_rec.data) begin
            report_mismatch("out_data", out_data, mem_rec.data);
        end
        if (mem_rec.redirect && redirect_pc !== mem_rec.target) begin
            report_mismatch("redirect_pc", redirect_pc, mem_rec.target);
        end
    end

    initial begin : watchdog
        #((TOTAL_INSTR + RESET_CYCLES + 100) * PERIOD);
        $display("Watchdog expired at time %0t before the stimulus finished", $time);
        $display("tests failed");
        $finish;
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] base;
        rst      = 1'b1;
        in_valid = 1'b0;
        opcode   = '0;
        funct3   = '0;
        funct7_5 = 1'b0;
        rd       = '0;
        use_imm  = 1'b0;
        pc       = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        imm      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) send_idle();

        // Every word written once so no load sees an unwritten lane
        for (int i = 0; i < DATA_WORDS; i++) begin
            send(rv32i_pkg::op_store, 3'b010, 1'b0, 5'd0, rand_pc(), i * 4,
                 fill_word(i), 32'd0);
        end

        for (int i = 0; i < N_ALU; i++) begin
            send_alu(i % 12);
        end

        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < N_BRANCH; i++) begin
                send_branch(k);
            end
        end

        for (int i = 0; i < N_JUMP; i++) begin
            send_jump(1'b0);
            send_jump(1'b1);
        end

        // Each store width and offset, then every load form on that word
        for (int round = 0; round < MEM_ROUNDS; round++) begin
            for (int w = 0; w < 3; w++) begin
                for (int off = 0; off < 4; off++) begin
                    base = rand_word();
                    send_mem(rv32i_pkg::op_store, 3'(w), {base[31:2], 2'(off)});
                    for (int k = 0; k < 5; k++) begin
                        for (int loff = 0; loff < 4; loff++) begin
                            send_mem(rv32i_pkg::op_load, load_funct3(k),
                                     {base[31:2], 2'(loff)});
                        end
                    end
                end
            end
        end

        for (int i = 0; i < N_MIX; i++) begin
            r = rand_word();
            case (r % 6)
                0, 1: send_alu(int'(r[7:4]) % 12);
                2:    send_branch(int'(r[10:8]) % 6);
                3:    send_jump(r[4]);
                4:    send_mem(rv32i_pkg::op_store, (r[5:4] == 2'd3) ? 3'b010 : {1'b0, r[5:4]},
                               rand_word());
                default: send_mem(rv32i_pkg::op_load, load_funct3(int'(r[6:4]) % 5),
                                  rand_word());
            endcase
        end

        send_idle();
        send_idle();

        $display("cycles checked %0d, mismatches %0d, assertion failures %0d",
                 cycles_checked, mismatches, dut_i.stage_i.chk_i.fail_count);
        if (mismatches == 0 && dut_i.stage_i.chk_i.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
source/rv32i_pkg.sv
source/ex_mem_if.sv
source/exec_unit.sv
source/ex_mem_stage.sv
source/mem_access.sv
source/data_ram.sv
source/ex_mem_top.sv
tb/tb_clock.sv
tb/ex_mem_chk.sv
tb/ex_mem_tb.sv
